//--- verilog/icache_pkg.sv
package icache_pkg;

  // cache geometry.
  localparam int offset_bits = 3;
  localparam int index_bits  = 5;
  localparam int tag_bits    = 8;
  localparam int cache_lines = 1 << index_bits;

  // bus widths.
  localparam int addr_bits    = 64;
  localparam int word_bits    = 64;
  localparam int mem_tag_bits = 4;

  typedef logic [addr_bits-1:0]    addr_t;
  typedef logic [word_bits-1:0]    word_t;
  typedef logic [mem_tag_bits-1:0] mem_tag_t;
  typedef logic [index_bits-1:0]   cache_index_t;
  typedef logic [tag_bits-1:0]     cache_tag_t;

  // tag value 0 is reserved for "no transaction".
  localparam mem_tag_t no_mem_tag = '0;

  typedef enum logic [1:0] {
    bus_none = 2'h0,
    bus_load = 2'h1
  } bus_command_t;

  // request towards memory, address is line aligned.
  typedef struct packed {
    bus_command_t command;
    addr_t        addr;
  } mem_req_t;

  // data beat from memory.
  typedef struct packed {
    mem_tag_t tag;
    word_t    data;
  } mem_data_t;

  // line fill from controller to the array.
  typedef struct packed {
    logic         en;
    cache_index_t index;
    cache_tag_t   tag;
    word_t        data;
  } cache_wr_t;

  // index field sits just above the byte offset.
  function automatic cache_index_t addr_index(addr_t addr);
    return addr[offset_bits +: index_bits];
  endfunction

  // tag field sits just above the index.
  function automatic cache_tag_t addr_tag(addr_t addr);
    return addr[offset_bits + index_bits +: tag_bits];
  endfunction

  function automatic addr_t line_addr(addr_t addr);
    addr_t aligned;
    aligned = addr;
    aligned[offset_bits-1:0] = '0;
    return aligned;
  endfunction

endpackage

//--- verilog/icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl (
  input  logic                  clock,
  input  logic                  reset,
  input  icache_pkg::addr_t     fetch_addr,
  input  logic                  hit,
  input  icache_pkg::mem_tag_t  mem_response,
  input  icache_pkg::mem_data_t mem_data,
  output icache_pkg::mem_req_t  mem_req,
  output icache_pkg::cache_wr_t cache_wr
);

  // fields of the current fetch address.
  icache_pkg::cache_index_t current_index;
  icache_pkg::cache_tag_t   current_tag;

  // address seen in the previous cycle.
  icache_pkg::cache_index_t last_index;
  icache_pkg::cache_tag_t   last_tag;
  logic                     primed;

  // miss bookkeeping.
  logic                 miss_outstanding;
  icache_pkg::mem_tag_t held_tag;

  logic changed_addr;
  logic tag_held;
  logic send_request;
  logic granted;
  logic fill;

  assign current_index = icache_pkg::addr_index(fetch_addr);
  assign current_tag   = icache_pkg::addr_tag(fetch_addr);

  // first cycle out of reset is treated as a new address.
  assign changed_addr = !primed ||
                        (current_index != last_index) ||
                        (current_tag != last_tag);

  assign tag_held = (held_tag != icache_pkg::no_mem_tag);

  // ask memory until it hands out a tag.
  assign send_request = miss_outstanding && !changed_addr && !tag_held;

  // nonzero response means memory took the load.
  assign granted = send_request && (mem_response != icache_pkg::no_mem_tag);

  // only the beat carrying our own tag fills the line.
  assign fill = tag_held && !changed_addr && (mem_data.tag == held_tag);

  always_comb begin
    mem_req.command = send_request ? icache_pkg::bus_load : icache_pkg::bus_none;
    mem_req.addr    = icache_pkg::line_addr(fetch_addr);
  end

  always_comb begin
    cache_wr.en    = fill;
    cache_wr.index = current_index;
    cache_wr.tag   = current_tag;
    cache_wr.data  = mem_data.data;
  end

  // address tracking.
  always_ff @(posedge clock) begin
    if (reset) begin
      primed     <= 1'b0;
      last_index <= '0;
      last_tag   <= '0;
    end else begin
      primed     <= 1'b1;
      last_index <= current_index;
      last_tag   <= current_tag;
    end
  end

  // a new address restarts the miss, a fill ends it.
  always_ff @(posedge clock) begin
    if (reset) begin
      miss_outstanding <= 1'b0;
    end else if (changed_addr) begin
      miss_outstanding <= !hit;
    end else if (fill) begin
      miss_outstanding <= 1'b0;
    end
  end

  // granted tag is dropped on an address change so late beats are ignored.
  always_ff @(posedge clock) begin
    if (reset) begin
      held_tag <= icache_pkg::no_mem_tag;
    end else if (changed_addr || fill) begin
      held_tag <= icache_pkg::no_mem_tag;
    end else if (granted) begin
      held_tag <= mem_response;
    end
  end

endmodule

//--- verilog/icache_mem.sv
`timescale 1ns/100ps

module icache_mem (
  input  logic                     clock,
  input  logic                     reset,
  input  icache_pkg::cache_index_t index,
  input  icache_pkg::cache_tag_t   tag,
  input  icache_pkg::cache_wr_t    cache_wr,
  output logic                     hit,
  output icache_pkg::word_t        data
);

  // payload of one line.
  typedef struct packed {
    icache_pkg::cache_tag_t tag;
    icache_pkg::word_t      data;
  } line_t;

  line_t                              lines [icache_pkg::cache_lines];
  logic [icache_pkg::cache_lines-1:0] valid;

  line_t entry;
  logic  entry_valid;
  line_t fill_line;

  // combinational lookup.
  always_comb begin
    entry       = lines[index];
    entry_valid = valid[index];
  end

  assign hit  = entry_valid && (entry.tag == tag);
  assign data = entry.data;

  always_comb begin
    fill_line.tag  = cache_wr.tag;
    fill_line.data = cache_wr.data;
  end

  // line storage, written on a fill.
  always_ff @(posedge clock) begin
    if (cache_wr.en) begin
      lines[cache_wr.index] <= fill_line;
    end
  end

  // valid bits, cleared as a whole on reset.
  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
    end else if (cache_wr.en) begin
      valid[cache_wr.index] <= 1'b1;
    end
  end

endmodule

//--- verilog/icache_top.sv
`timescale 1ns/100ps

module icache_top (
  input  logic                  clock,
  input  logic                  reset,
  input  icache_pkg::addr_t     fetch_addr,
  input  icache_pkg::mem_tag_t  mem_response,
  input  icache_pkg::mem_data_t mem_data,
  output icache_pkg::mem_req_t  mem_req,
  output icache_pkg::word_t     fetch_data,
  output logic                  fetch_valid
);

  icache_pkg::cache_index_t index;
  icache_pkg::cache_tag_t   tag;
  icache_pkg::cache_wr_t    cache_wr;
  icache_pkg::word_t        line_data;
  logic                     hit;

  // split the fetch address for the lookup.
  assign index = icache_pkg::addr_index(fetch_addr);
  assign tag   = icache_pkg::addr_tag(fetch_addr);

  icache_ctrl ctrl0 (
    .clock        (clock),
    .reset        (reset),
    .fetch_addr   (fetch_addr),
    .hit          (hit),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_req      (mem_req),
    .cache_wr     (cache_wr)
  );

  icache_mem mem0 (
    .clock    (clock),
    .reset    (reset),
    .index    (index),
    .tag      (tag),
    .cache_wr (cache_wr),
    .hit      (hit),
    .data     (line_data)
  );

  // hit gives the word in the same cycle.
  assign fetch_valid = hit;
  assign fetch_data  = line_data;

endmodule

//--- test/icache_properties.sv
`timescale 1ns/100ps

module icache_properties (
  input logic                 clock,
  input logic                 reset,
  input icache_pkg::mem_req_t mem_req,
  input logic                 fetch_valid
);

  // count of failed assertions.
  int unsigned failure_count = 0;

  // requests always name a whole line.
  aligned_request: assert property (@(posedge clock)
    mem_req.addr[icache_pkg::offset_bits-1:0] == '0)
    else begin
      failure_count++;
      $error("mem_req address has nonzero offset bits");
    end

  // a hit never goes to memory.
  no_load_on_hit: assert property (@(posedge clock) disable iff (reset)
    fetch_valid |-> mem_req.command != icache_pkg::bus_load)
    else begin
      failure_count++;
      $error("bus_load issued while fetch_valid is high");
    end

  // valid bits are all clear out of reset.
  empty_after_reset: assert property (@(posedge clock)
    $fell(reset) |-> !fetch_valid)
    else begin
      failure_count++;
      $error("fetch_valid high in the first cycle after reset");
    end

endmodule

//--- test/icache_tb.sv
`timescale 1ns/100ps

module icache_tb;

  // one entry of the fetch sequence.
  typedef struct packed {
    icache_pkg::addr_t addr;
    logic [3:0]        hold;
    logic              expect_hit;
    logic              wait_valid;
    logic              refusals;
    logic              reset_first;
  } step_t;

  localparam int step_count  = 17;
  localparam int cycle_limit = step_count * 64;
  localparam icache_pkg::word_t data_mask = 64'h5a5a_0000_1234_abcd;

  // addr, hold, hit on first cycle, wait for valid, refusals, reset first.
  step_t steps [step_count] = '{
    '{64'h1208, 4'd1, 1'b0, 1'b1, 1'b0, 1'b0},
    '{64'h1310, 4'd1, 1'b0, 1'b1, 1'b0, 1'b0},
    '{64'h120c, 4'd2, 1'b1, 1'b0, 1'b0, 1'b0},
    '{64'h1310, 4'd1, 1'b1, 1'b0, 1'b0, 1'b0},
    '{64'h3408, 4'd1, 1'b0, 1'b1, 1'b0, 1'b0},
    '{64'h1208, 4'd1, 1'b0, 1'b1, 1'b0, 1'b0},
    '{64'h0538, 4'd2, 1'b0, 1'b1, 1'b1, 1'b0},
    '{64'h0640, 4'd1, 1'b0, 1'b1, 1'b1, 1'b0},
    '{64'h0748, 4'd1, 1'b0, 1'b1, 1'b1, 1'b0},
    '{64'h0538, 4'd1, 1'b1, 1'b0, 1'b1, 1'b0},
    '{64'h1310, 4'd1, 1'b1, 1'b0, 1'b0, 1'b0},
    '{64'h0850, 4'd2, 1'b0, 1'b0, 1'b0, 1'b0},
    '{64'h0958, 4'd1, 1'b0, 1'b1, 1'b0, 1'b0},
    '{64'h0850, 4'd1, 1'b0, 1'b1, 1'b0, 1'b0},
    '{64'h1208, 4'd1, 1'b1, 1'b0, 1'b0, 1'b0},
    '{64'h1208, 4'd1, 1'b0, 1'b1, 1'b0, 1'b1},
    '{64'h1310, 4'd1, 1'b0, 1'b1, 1'b0, 1'b0}
  };

  logic                  clock;
  logic                  reset;
  icache_pkg::addr_t     fetch_addr;
  icache_pkg::mem_tag_t  mem_response;
  icache_pkg::mem_data_t mem_data;
  icache_pkg::mem_req_t  mem_req;
  icache_pkg::word_t     fetch_data;
  logic                  fetch_valid;

  // memory model state.
  logic [31:0]          lfsr;
  logic                 refusals_on;
  logic                 refuse_now;
  icache_pkg::mem_tag_t next_tag = 4'd1;
  icache_pkg::mem_tag_t beat_tag [$];
  icache_pkg::addr_t    beat_addr [$];
  int unsigned          beat_due [$];
  int unsigned          cycle_count = 0;
  int unsigned          load_count = 0;
  int unsigned          refusal_count = 0;

  icache_top dut0 (
    .clock        (clock),
    .reset        (reset),
    .fetch_addr   (fetch_addr),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_req      (mem_req),
    .fetch_data   (fetch_data),
    .fetch_valid  (fetch_valid)
  );

  bind icache_top icache_properties props0 (
    .clock       (clock),
    .reset       (reset),
    .mem_req     (mem_req),
    .fetch_valid (fetch_valid)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // memory answers in the same cycle as the request.
  assign mem_response = (!reset && mem_req.command == icache_pkg::bus_load && !refuse_now)
                        ? next_tag : icache_pkg::no_mem_tag;

  // fibonacci lfsr with taps 32 22 2 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  function automatic icache_pkg::addr_t aligned(input icache_pkg::addr_t addr);
    return {addr[63:3], 3'b000};
  endfunction

  // memory content is the line address scrambled.
  function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t addr);
    return aligned(addr) ^ data_mask;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // one cycle of inputs applied on the falling edge.
  task automatic drive_cycle(input icache_pkg::addr_t addr, input logic hold_reset);
    @(negedge clock);
    reset      = hold_reset;
    fetch_addr = addr;
    refuse_now = 1'b0;
    if (refusals_on && !hold_reset) begin
      lfsr       = lfsr_step(lfsr);
      refuse_now = lfsr[0];
    end
    mem_data = '0;
    if (hold_reset) begin
      beat_tag.delete();
      beat_addr.delete();
      beat_due.delete();
    end else if (beat_due.size() > 0 && beat_due[0] <= cycle_count) begin
      mem_data.tag  = beat_tag.pop_front();
      mem_data.data = expected_word(beat_addr.pop_front());
      beat_due.delete(0);
    end
  endtask

  // bus monitor, grant bookkeeping, assertion watch and timeout.
  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (dut0.props0.failure_count != 0) begin
      $display("a bus or output assertion on icache_top failed");
      $display("Simulation FAILED");
      $fatal(1, "assertion failure");
    end else if (cycle_count >= cycle_limit) begin
      $display("timeout: fetch sequence did not finish within %0d cycles", cycle_limit);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end else if (!reset && mem_req.command == icache_pkg::bus_load) begin
      load_count <= load_count + 1;
      check_value("mem_req.addr", mem_req.addr, aligned(fetch_addr));
      if (mem_response != icache_pkg::no_mem_tag) begin
        beat_tag.push_back(mem_response);
        beat_addr.push_back(mem_req.addr);
        beat_due.push_back(cycle_count + 4);
        next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end else begin
        refusal_count <= refusal_count + 1;
      end
    end
  end

  initial begin
    step_t       step;
    int unsigned loads_before;
    reset       = 1'b1;
    fetch_addr  = '0;
    mem_data    = '0;
    refusals_on = 1'b0;
    refuse_now  = 1'b0;
    lfsr        = 32'ha68e_6625;
    repeat (10) drive_cycle('0, 1'b1);

    for (int i = 0; i < step_count; i++) begin
      step        = steps[i];
      refusals_on = step.refusals;
      if (step.reset_first) begin
        repeat (10) drive_cycle(step.addr, 1'b1);
      end
      drive_cycle(step.addr, 1'b0);
      loads_before = load_count;
      @(posedge clock);
      check_value("fetch_valid", fetch_valid, step.expect_hit);
      if (step.expect_hit) begin
        check_value("fetch_data", fetch_data, expected_word(step.addr));
        check_value("mem_req.command", mem_req.command, icache_pkg::bus_none);
      end
      if (step.wait_valid) begin
        while (!fetch_valid) begin
          drive_cycle(step.addr, 1'b0);
          @(posedge clock);
        end
        check_value("fetch_data", fetch_data, expected_word(step.addr));
        if (!step.expect_hit) begin
          check_value("bus_load issued", load_count > loads_before, 1'b1);
        end
      end
      repeat (step.hold) drive_cycle(step.addr, 1'b0);
    end

    // the refusal entries must have forced at least one retry.
    check_value("refusal seen", refusal_count != 0, 1'b1);
    if (dut0.props0.failure_count == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("%0d assertion failures during the run", dut0.props0.failure_count);
      $display("Simulation FAILED");
      $fatal(1, "assertion failures");
    end
  end

endmodule

//--- list.f
verilog/icache_pkg.sv
verilog/icache_ctrl.sv
verilog/icache_mem.sv
verilog/icache_top.sv
test/icache_properties.sv
test/icache_tb.sv
